//--- verilog/riscv_cfg.svh
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// field and datapath widths
`define XLEN            32
`define REG_NUM         32          // x0..x31
`define REG_ADDR_WIDTH  5
`define OPCODE_WIDTH    7
`define FUNCT3_WIDTH    3
`define FUNCT7_WIDTH    7

// rv32i major opcodes, inst[6:0]
`define LUI     7'b011_0111
`define AUIPC   7'b001_0111
`define JAL     7'b110_1111
`define JALR    7'b110_0111
`define BRANCH  7'b110_0011
`define LOAD    7'b000_0011
`define STORE   7'b010_0011
`define OP_IMM  7'b001_0011
`define OP      7'b011_0011
`define FENCE   7'b000_1111
`define SYS     7'b111_0011

// alu operation codes
`define ALU_OPT_WIDTH   4
`define ALU_NONE        4'd0
`define ALU_ADD         4'd1
`define ALU_SUB         4'd2
`define ALU_SLT         4'd3
`define ALU_SLTU        4'd4
`define ALU_XOR         4'd5
`define ALU_OR          4'd6
`define ALU_AND         4'd7
`define ALU_SLL         4'd8
`define ALU_SRL         4'd9
`define ALU_SRA         4'd10

// operand source select, (op_a, op_b)
`define SRC_SEL_WIDTH   2
`define SRC_SEL_RS1_IMM 2'd0
`define SRC_SEL_RS1_2   2'd1
`define SRC_SEL_PC_IMM  2'd2
`define SRC_SEL_PC_4    2'd3

// lsu option
`define LSU_OPT_WIDTH   2
`define LSU_OPT_NONE    2'd0
`define LSU_OPT_LOAD    2'd1
`define LSU_OPT_STORE   2'd2
`define LSU_OPT_SYS     2'd3

`endif

//--- verilog/riscv_pkg.sv
`include "riscv_cfg.svh"

package riscv_pkg;

    // data, address and pc values
    typedef logic [`XLEN-1:0]           word_t;

    // register file index
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // decode outputs, encodings in riscv_cfg.svh
    typedef logic [`ALU_OPT_WIDTH-1:0]  alu_opt_t;   // `ALU_*
    typedef logic [`SRC_SEL_WIDTH-1:0]  src_sel_t;   // `SRC_SEL_*
    typedef logic [`LSU_OPT_WIDTH-1:0]  lsu_opt_t;   // `LSU_OPT_*

endpackage

//--- verilog/riscv_id_ex_if.sv
`include "riscv_cfg.svh"

// registered decode bundle, id -> ex
interface riscv_id_ex_if;
    import riscv_pkg::*;

    logic                       valid;      // one instruction in ex this cycle
    word_t                      pc;
    word_t                      imm;        // already sign extended
    reg_addr_t                  rs1;
    reg_addr_t                  rs2;
    reg_addr_t                  rd;
    logic [`FUNCT3_WIDTH-1:0]   funct3;     // branch condition select
    alu_opt_t                   alu_opt;
    src_sel_t                   src_sel;
    lsu_opt_t                   lsu_opt;
    logic                       wb_en;      // rd write, rd != x0
    logic                       is_branch;
    logic                       is_jal;
    logic                       is_jalr;

    modport id (
        output valid, pc, imm, rs1, rs2, rd, funct3,
        output alu_opt, src_sel, lsu_opt, wb_en, is_branch, is_jal, is_jalr
    );

    modport ex (
        input valid, pc, imm, rs1, rs2, rd, funct3,
        input alu_opt, src_sel, lsu_opt, wb_en, is_branch, is_jal, is_jalr
    );

endinterface

//--- verilog/riscv_id_opt.sv
`include "riscv_cfg.svh"

module riscv_id_opt (
    input  logic [`OPCODE_WIDTH-1:0]    opcode,
    input  logic [`FUNCT3_WIDTH-1:0]    funct3,
    input  logic [`FUNCT7_WIDTH-1:0]    funct7,
    output riscv_pkg::alu_opt_t         alu_opt,
    output riscv_pkg::src_sel_t         src_sel,
    output riscv_pkg::lsu_opt_t         lsu_opt
);

    // alu operation
    always_comb begin
        alu_opt = `ALU_NONE;
        case (opcode)
            `LUI, `AUIPC, `JAL, `JALR: begin
                alu_opt = `ALU_ADD;             // imm, pc+imm, pc+4
            end
            `BRANCH: begin
                case (funct3)
                    3'b000, 3'b001: alu_opt = `ALU_SUB;    // beq, bne on zero test
                    3'b100, 3'b101: alu_opt = `ALU_SLT;    // blt, bge
                    3'b110, 3'b111: alu_opt = `ALU_SLTU;   // bltu, bgeu
                    default:        alu_opt = `ALU_NONE;
                endcase
            end
            `LOAD, `STORE: begin
                alu_opt = `ALU_NONE;            // address comes from the agu adder
            end
            `OP_IMM: begin
                case (funct3)
                    3'b000: alu_opt = `ALU_ADD;     // addi
                    3'b010: alu_opt = `ALU_SLT;     // slti, signed compare
                    3'b011: alu_opt = `ALU_SLTU;    // sltiu
                    3'b100: alu_opt = `ALU_XOR;     // xori
                    3'b110: alu_opt = `ALU_OR;      // ori
                    3'b111: alu_opt = `ALU_AND;     // andi
                    3'b001: alu_opt = `ALU_SLL;     // slli
                    3'b101: begin
                        case (funct7)
                            7'b000_0000: alu_opt = `ALU_SRL;   // srli
                            7'b010_0000: alu_opt = `ALU_SRA;   // srai
                            default:     alu_opt = `ALU_NONE;
                        endcase
                    end
                    default: alu_opt = `ALU_NONE;
                endcase
            end
            `OP: begin
                case (funct3)
                    3'b000: begin
                        case (funct7)
                            7'b000_0000: alu_opt = `ALU_ADD;   // add
                            7'b010_0000: alu_opt = `ALU_SUB;   // sub
                            default:     alu_opt = `ALU_NONE;
                        endcase
                    end
                    3'b001: alu_opt = `ALU_SLL;     // sll
                    3'b010: alu_opt = `ALU_SLT;     // slt
                    3'b011: alu_opt = `ALU_SLTU;    // sltu
                    3'b100: alu_opt = `ALU_XOR;     // xor
                    3'b101: begin
                        case (funct7)
                            7'b000_0000: alu_opt = `ALU_SRL;   // srl
                            7'b010_0000: alu_opt = `ALU_SRA;   // sra
                            default:     alu_opt = `ALU_NONE;
                        endcase
                    end
                    3'b110: alu_opt = `ALU_OR;      // or
                    3'b111: alu_opt = `ALU_AND;     // and
                    default: alu_opt = `ALU_NONE;
                endcase
            end
            `FENCE, `SYS: alu_opt = `ALU_AND;   // treated as nop, no writeback
            default:      alu_opt = `ALU_NONE;
        endcase
    end

    // operand source
    always_comb begin
        case (opcode)
            `AUIPC:       src_sel = `SRC_SEL_PC_IMM;
            `JAL, `JALR:  src_sel = `SRC_SEL_PC_4;   // link value
            `BRANCH, `OP: src_sel = `SRC_SEL_RS1_2;
            default:      src_sel = `SRC_SEL_RS1_IMM; // lui via x0, load/store, op_imm
        endcase
    end

    // lsu request type
    always_comb begin
        case (opcode)
            `LOAD:   lsu_opt = `LSU_OPT_LOAD;
            `STORE:  lsu_opt = `LSU_OPT_STORE;
            `SYS:    lsu_opt = `LSU_OPT_SYS;     // ecall/ebreak flagged downstream
            default: lsu_opt = `LSU_OPT_NONE;
        endcase
    end

endmodule

//--- verilog/riscv_id_stage.sv
`include "riscv_cfg.svh"

module riscv_id_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid,
    input  riscv_pkg::word_t    inst,
    input  riscv_pkg::word_t    pc,
    riscv_id_ex_if.id           id_ex
);
    import riscv_pkg::*;

    logic [`OPCODE_WIDTH-1:0]   opcode;
    logic [`FUNCT3_WIDTH-1:0]   funct3;
    logic [`FUNCT7_WIDTH-1:0]   funct7;
    reg_addr_t                  rd;
    reg_addr_t                  rs1;
    reg_addr_t                  rs2;
    word_t                      imm;
    logic                       wb_en;
    alu_opt_t                   alu_opt;
    src_sel_t                   src_sel;
    lsu_opt_t                   lsu_opt;

    // fixed rv32i field positions
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];
    assign rs1    = (opcode == `LUI) ? '0 : inst[19:15];  // lui reads x0, so x0+imm

    riscv_id_opt id_opt_inst (
        .opcode  (opcode),
        .funct3  (funct3),
        .funct7  (funct7),
        .alu_opt (alu_opt),
        .src_sel (src_sel),
        .lsu_opt (lsu_opt)
    );

    // immediate by format
    always_comb begin
        case (opcode)
            `LUI, `AUIPC: imm = {inst[31:12], 12'b0};                                   // u
            `JAL:    imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};  // j
            `BRANCH: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};    // b
            `STORE:  imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};                   // s
            default: imm = {{21{inst[31]}}, inst[30:20]};                               // i
        endcase
    end

    // register writers only, x0 never written
    always_comb begin
        case (opcode)
            `LUI, `AUIPC, `JAL, `JALR, `OP, `OP_IMM: wb_en = (rd != '0);
            default:                                 wb_en = 1'b0;
        endcase
    end

    // control half of the bundle
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid     <= 1'b0;
            id_ex.wb_en     <= 1'b0;
            id_ex.is_branch <= 1'b0;
            id_ex.is_jal    <= 1'b0;
            id_ex.is_jalr   <= 1'b0;
        end else begin
            id_ex.valid     <= inst_valid;
            id_ex.wb_en     <= inst_valid & wb_en;
            id_ex.is_branch <= inst_valid & (opcode == `BRANCH);
            id_ex.is_jal    <= inst_valid & (opcode == `JAL);
            id_ex.is_jalr   <= inst_valid & (opcode == `JALR);
        end
    end

    // payload, only loaded with a new instruction
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            id_ex.pc      <= pc;
            id_ex.imm     <= imm;
            id_ex.rs1     <= rs1;
            id_ex.rs2     <= rs2;
            id_ex.rd      <= rd;
            id_ex.funct3  <= funct3;
            id_ex.alu_opt <= alu_opt;
            id_ex.src_sel <= src_sel;
            id_ex.lsu_opt <= lsu_opt;
        end
    end

endmodule

//--- verilog/riscv_regfile.sv
`include "riscv_cfg.svh"

module riscv_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  riscv_pkg::reg_addr_t    raddr1,
    input  riscv_pkg::reg_addr_t    raddr2,
    output riscv_pkg::word_t        rdata1,
    output riscv_pkg::word_t        rdata2,
    input  logic                    we,
    input  riscv_pkg::reg_addr_t    waddr,
    input  riscv_pkg::word_t        wdata
);
    import riscv_pkg::*;

    word_t regs [1:`REG_NUM-1];     // x1..x31, x0 has no storage

    // async read, x0 hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;       // x0 writes dropped
        end
    end

endmodule

//--- verilog/riscv_exu.sv
`include "riscv_cfg.svh"

module riscv_exu (
    input  logic                    clk,
    input  logic                    rst,
    riscv_id_ex_if.ex               id_ex,
    output riscv_pkg::reg_addr_t    raddr1,
    output riscv_pkg::reg_addr_t    raddr2,
    input  riscv_pkg::word_t        rdata1,
    input  riscv_pkg::word_t        rdata2,
    output logic                    we,
    output riscv_pkg::reg_addr_t    waddr,
    output riscv_pkg::word_t        wdata,
    output logic                    result_valid,
    output riscv_pkg::word_t        result,
    output riscv_pkg::reg_addr_t    rd,
    output riscv_pkg::lsu_opt_t     lsu_opt,
    output riscv_pkg::word_t        mem_addr,
    output riscv_pkg::word_t        store_data,
    output logic                    redirect,
    output riscv_pkg::word_t        target
);
    import riscv_pkg::*;

    // branch condition, values are the funct3 encodings
    typedef enum logic [`FUNCT3_WIDTH-1:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_t;

    br_cond_t   br_cond;
    word_t      op_a;
    word_t      op_b;
    word_t      alu_res;
    word_t      addr_sum;   // rs1+imm, jalr target and load/store address
    logic       taken;
    logic       redirect_nxt;
    word_t      target_nxt;

    assign raddr1 = id_ex.rs1;
    assign raddr2 = id_ex.rs2;

    // operand mux
    always_comb begin
        case (id_ex.src_sel)
            `SRC_SEL_RS1_2:  begin op_a = rdata1;   op_b = rdata2;    end
            `SRC_SEL_PC_IMM: begin op_a = id_ex.pc; op_b = id_ex.imm; end
            `SRC_SEL_PC_4:   begin op_a = id_ex.pc; op_b = 32'd4;     end
            default:         begin op_a = rdata1;   op_b = id_ex.imm; end
        endcase
    end

    always_comb begin
        case (id_ex.alu_opt)
            `ALU_ADD:  alu_res = op_a + op_b;
            `ALU_SUB:  alu_res = op_a - op_b;
            `ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            `ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            `ALU_XOR:  alu_res = op_a ^ op_b;
            `ALU_OR:   alu_res = op_a | op_b;
            `ALU_AND:  alu_res = op_a & op_b;
            `ALU_SLL:  alu_res = op_a << op_b[4:0];               // shamt, low 5 bits
            `ALU_SRL:  alu_res = op_a >> op_b[4:0];
            `ALU_SRA:  alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            default:   alu_res = '0;
        endcase
    end

    // branch decision off the alu result
    assign br_cond = br_cond_t'(id_ex.funct3);

    always_comb begin
        case (br_cond)
            BR_EQ:          taken = (alu_res == '0);
            BR_NE:          taken = (alu_res != '0);
            BR_LT, BR_LTU:  taken = alu_res[0];
            BR_GE, BR_GEU:  taken = ~alu_res[0];
            default:        taken = 1'b0;    // 010/011 not a branch
        endcase
    end

    assign addr_sum     = rdata1 + id_ex.imm;
    assign redirect_nxt = id_ex.valid &
                          (id_ex.is_jal | id_ex.is_jalr | (id_ex.is_branch & taken));
    assign target_nxt   = id_ex.is_jalr ? {addr_sum[31:1], 1'b0} : id_ex.pc + id_ex.imm;

    // writeback lands on the same edge as the output registers
    assign we    = id_ex.valid & id_ex.wb_en;
    assign waddr = id_ex.rd;
    assign wdata = alu_res;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            redirect     <= 1'b0;
            lsu_opt      <= `LSU_OPT_NONE;
        end else begin
            result_valid <= id_ex.valid;
            redirect     <= redirect_nxt;
            lsu_opt      <= id_ex.valid ? id_ex.lsu_opt : `LSU_OPT_NONE;  // no stray requests
        end
    end

    // payload outputs, qualified by result_valid
    always_ff @(posedge clk) begin
        result     <= alu_res;
        rd         <= id_ex.rd;
        mem_addr   <= addr_sum;
        store_data <= rdata2;
        target     <= target_nxt;
    end

endmodule

//--- verilog/riscv_exec_core.sv
module riscv_exec_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst_valid,
    input  riscv_pkg::word_t        inst,
    input  riscv_pkg::word_t        pc,
    output logic                    result_valid,
    output riscv_pkg::word_t        result,
    output riscv_pkg::reg_addr_t    rd,
    output riscv_pkg::lsu_opt_t     lsu_opt,
    output riscv_pkg::word_t        mem_addr,
    output riscv_pkg::word_t        store_data,
    output logic                    redirect,
    output riscv_pkg::word_t        target
);
    import riscv_pkg::*;

    // ex <-> register file
    reg_addr_t  rf_raddr1;
    reg_addr_t  rf_raddr2;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    logic       rf_we;
    reg_addr_t  rf_waddr;
    word_t      rf_wdata;

    riscv_id_ex_if id_ex_if ();

    riscv_id_stage id_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .id_ex      (id_ex_if)
    );

    riscv_exu exu_inst (
        .clk          (clk),
        .rst          (rst),
        .id_ex        (id_ex_if),
        .raddr1       (rf_raddr1),
        .raddr2       (rf_raddr2),
        .rdata1       (rf_rdata1),
        .rdata2       (rf_rdata2),
        .we           (rf_we),
        .waddr        (rf_waddr),
        .wdata        (rf_wdata),
        .result_valid (result_valid),
        .result       (result),
        .rd           (rd),
        .lsu_opt      (lsu_opt),
        .mem_addr     (mem_addr),
        .store_data   (store_data),
        .redirect     (redirect),
        .target       (target)
    );

    riscv_regfile regfile_inst (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

//--- sim/tb_riscv_model.svh
`ifndef TB_RISCV_MODEL_SVH
`define TB_RISCV_MODEL_SVH

// architectural registers as the model sees them, entry 0 unused
word_t shadow_rf [0:31];

function automatic word_t reg_read(input reg_addr_t idx);
    return (idx == 5'd0) ? 32'd0 : shadow_rf[idx];
endfunction

function automatic void reg_write(input reg_addr_t idx, input word_t val);
    if (idx != 5'd0) begin
        shadow_rf[idx] = val;   // x0 keeps reading zero
    end
endfunction

// immediate per isa format
function automatic word_t imm_of(input word_t inst);
    case (inst[6:0])
        `LUI, `AUIPC: return {inst[31:12], 12'h000};
        `JAL:    return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        `BRANCH: return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        `STORE:  return {{20{inst[31]}}, inst[31:25], inst[11:7]};
        default: return {{20{inst[31]}}, inst[31:20]};
    endcase
endfunction

function automatic logic is_writer(input logic [6:0] opc);
    return (opc == `LUI) || (opc == `AUIPC) || (opc == `JAL) || (opc == `JALR) ||
           (opc == `OP) || (opc == `OP_IMM);
endfunction

function automatic lsu_opt_t lsu_of(input logic [6:0] opc);
    case (opc)
        `LOAD:   return `LSU_OPT_LOAD;
        `STORE:  return `LSU_OPT_STORE;
        `SYS:    return `LSU_OPT_SYS;     // ecall, ebreak
        default: return `LSU_OPT_NONE;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        3'd7:    return a >= b;
        default: return 1'b0;
    endcase
endfunction

// value an instruction leaves in rd
function automatic word_t wb_value(input word_t inst, input word_t ipc);
    word_t      a;
    word_t      b;
    word_t      imm;
    logic [4:0] sh;
    logic       alt;
    imm = imm_of(inst);
    a   = reg_read(inst[19:15]);
    b   = (inst[6:0] == `OP) ? reg_read(inst[24:20]) : imm;
    sh  = b[4:0];
    alt = inst[30];                         // sub / sra select
    case (inst[6:0])
        `LUI:        return imm;
        `AUIPC:      return ipc + imm;
        `JAL, `JALR: return ipc + 32'd4;    // link
        default: begin
            case (inst[14:12])
                3'd0:    return (alt && inst[6:0] == `OP) ? a - b : a + b;
                3'd1:    return a << sh;
                3'd2:    return {31'd0, $signed(a) < $signed(b)};
                3'd3:    return {31'd0, a < b};
                3'd4:    return a ^ b;
                3'd5:    return alt ? word_t'($signed(a) >>> sh) : a >> sh;
                3'd6:    return a | b;
                default: return a & b;
            endcase
        end
    endcase
endfunction

`endif

//--- sim/tb_riscv_exec_core.sv
`include "riscv_cfg.svh"

module tb_riscv_exec_core;
    timeunit 1ns;
    timeprecision 1ps;
    import riscv_pkg::*;

    `include "tb_riscv_model.svh"

    localparam int RST_CYCLES = 5;
    localparam int NUM_SEED   = 62;     // lui + addi per register
    localparam int NUM_ALU    = 60;
    localparam int NUM_JUMP   = 6;
    localparam int NUM_BR     = 24;     // four of each branch type
    localparam int NUM_MEM    = 12;     // load, store and rd readback four times
    localparam int NUM_MISC   = 5;
    localparam int NUM_INST   = NUM_SEED + NUM_ALU + NUM_JUMP + NUM_BR + NUM_MEM + NUM_MISC;

    logic       clk;
    logic       rst;
    logic       inst_valid;
    word_t      inst;
    word_t      pc;
    logic       result_valid;
    word_t      result;
    reg_addr_t  rd;
    lsu_opt_t   lsu_opt;
    word_t      mem_addr;
    word_t      store_data;
    logic       redirect;
    word_t      target;

    logic [15:0] lfsr = 16'd65;
    word_t       inst_q [$];    // issued but not yet checked
    word_t       pc_q [$];
    int          checked = 0;

    riscv_exec_core riscv_exec_core_inst (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .result_valid (result_valid),
        .result       (result),
        .rd           (rd),
        .lsu_opt      (lsu_opt),
        .mem_addr     (mem_addr),
        .store_data   (store_data),
        .redirect     (redirect),
        .target       (target)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t dst);
        return {f7, rs2, rs1, f3, dst, `OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t dst,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, dst, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t dst,
                                     input logic [6:0] opc);
        return {imm, dst, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t dst);
        return {imm[20], imm[10:1], imm[11], imm[19:12], dst, `JAL};
    endfunction

    // one instruction on the next rising edge with a random word aligned pc
    task automatic issue(input word_t word);
        word_t pc_val;
        pc_val = {30'(rand_bits(30)), 2'b00};
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= word;
        pc         <= pc_val;
        inst_q.push_back(word);
        pc_q.push_back(pc_val);
    endtask

    task automatic idle();
        @(posedge clk);
        inst_valid <= 1'b0;
    endtask

    task automatic value_fail(input string name, input word_t got, input word_t exp);
        $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        $display("SIMULATION FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic seed_regs();
        for (int r = 1; r < 32; r++) begin
            issue(u_type(20'(rand_bits(20)), 5'(r), `LUI));
            issue(i_type(12'(rand_bits(12)), 5'(r), 3'd0, 5'(r), `OP_IMM));  // raw on lui
        end
        idle();
    endtask

    task automatic random_alu(input int n);
        reg_addr_t   dst;
        reg_addr_t   rs1;
        reg_addr_t   prev_rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        prev_rd = 5'd1;
        for (int k = 0; k < n; k++) begin
            dst = 5'(rand_bits(5));                                 // x0 now and then
            rs1 = (rand_bits(1) != 0) ? prev_rd : 5'(rand_bits(5)); // dependent pair
            f3  = 3'(rand_bits(3));
            f7  = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) != 0) ? 7'h20 : 7'h00;
            imm = 12'(rand_bits(12));
            if (rand_bits(1) != 0) begin
                issue(r_type(f7, 5'(rand_bits(5)), rs1, f3, dst));
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                issue(i_type({f7, imm[4:0]}, rs1, f3, dst, `OP_IMM));   // shamt form
            end else begin
                issue(i_type(imm, rs1, f3, dst, `OP_IMM));
            end
            if (rand_bits(2) == 0) begin
                idle();     // gap instead of back to back
            end
            prev_rd = dst;
        end
        idle();
    endtask

    task automatic jumps();
        for (int k = 0; k < NUM_JUMP / 3; k++) begin
            issue(u_type(20'(rand_bits(20)), 5'(rand_bits(5)), `AUIPC));
            issue(j_type(21'(rand_bits(21)), 5'(rand_bits(5))));
            issue(i_type(12'(rand_bits(12)), 5'(rand_bits(5)), 3'd0, 5'(rand_bits(5)), `JALR));
        end
        idle();
    endtask

    task automatic branches();
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [2:0] f3;
        for (int k = 0; k < NUM_BR; k++) begin
            f3  = (k % 6 < 2) ? 3'(k % 6) : 3'(k % 6 + 2);     // 0 1 4 5 6 7
            rs1 = 5'(rand_bits(5));
            rs2 = (rand_bits(2) == 0) ? rs1 : 5'(rand_bits(5)); // equal operands too
            issue(b_type(13'(rand_bits(13)), rs2, rs1, f3));
        end
        idle();
    endtask

    task automatic mem_ops();
        reg_addr_t   ld_rd;
        logic [11:0] st_imm;
        for (int k = 0; k < NUM_MEM / 3; k++) begin
            ld_rd  = 5'(rand_bits(5));
            st_imm = 12'(rand_bits(12));
            issue(i_type(12'(rand_bits(12)), 5'(rand_bits(5)), 3'd2, ld_rd, `LOAD));
            issue(s_type(st_imm, 5'(rand_bits(5)), 5'(rand_bits(5)), 3'd2));
            // both rd fields read back into x0, they still hold the model values
            issue(r_type(7'h00, st_imm[4:0], ld_rd, 3'd6, 5'd0));
        end
        idle();
    endtask

    task automatic misc_ops();
        issue(32'h0000_0073);                                   // ecall
        issue(32'h0000_000f);                                   // fence
        issue(i_type(12'h5a5, 5'd1, 3'd0, 5'd0, `OP_IMM));      // write to x0
        issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd2));           // x2 = x0 + x0
        issue(r_type(7'h00, 5'd0, 5'd2, 3'd6, 5'd3));           // x3 = x2 | x0
        idle();
    endtask

    // compare one retired instruction against the model and commit it
    task automatic check_result();
        word_t      word;
        word_t      ipc;
        word_t      imm;
        word_t      a;
        word_t      b;
        word_t      exp_val;
        word_t      exp_tgt;
        logic [6:0] opc;
        logic       exp_redir;
        if (inst_q.size() == 0) begin
            $display("result_valid raised with no instruction in flight");
            $display("SIMULATION FAILED");
            $fatal(1, "unexpected result");
        end
        word      = inst_q.pop_front();
        ipc       = pc_q.pop_front();
        opc       = word[6:0];
        imm       = imm_of(word);
        a         = reg_read(word[19:15]);
        b         = reg_read(word[24:20]);
        exp_redir = (opc == `JAL) || (opc == `JALR) ||
                    (opc == `BRANCH && branch_taken(word[14:12], a, b));
        exp_tgt   = (opc == `JALR) ? ((a + imm) & ~32'd1) : ipc + imm;
        assert (lsu_opt === lsu_of(opc)) else value_fail("lsu_opt", lsu_opt, lsu_of(opc));
        assert (redirect === exp_redir) else value_fail("redirect", redirect, exp_redir);
        if (exp_redir || opc == `BRANCH) begin
            assert (target === exp_tgt) else value_fail("target", target, exp_tgt);
        end
        if (opc == `LOAD || opc == `STORE) begin
            assert (mem_addr === a + imm) else value_fail("mem_addr", mem_addr, a + imm);
        end
        if (opc == `STORE) begin
            assert (store_data === b) else value_fail("store_data", store_data, b);
        end
        if (is_writer(opc)) begin
            exp_val = wb_value(word, ipc);
            assert (result === exp_val) else value_fail("result", result, exp_val);
            assert (rd === word[11:7]) else value_fail("rd", rd, word[11:7]);
            reg_write(word[11:7], exp_val);     // dropped for x0
        end
        checked++;
    endtask

    // outputs settle after the rising edge and are sampled mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (result_valid) begin
                check_result();
            end else begin
                assert (redirect === 1'b0) else value_fail("redirect", redirect, 32'd0);
            end
        end
    end

    // two cycle latency in both directions
    assert property (@(posedge clk) disable iff (rst) result_valid == $past(inst_valid, 2))
        else begin
            $display("result_valid did not follow inst_valid by exactly two cycles");
            $display("SIMULATION FAILED");
            $fatal(1, "latency mismatch");
        end

    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        foreach (shadow_rf[i]) begin
            shadow_rf[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);      // quiet window after reset
        seed_regs();
        random_alu(NUM_ALU);
        jumps();
        branches();
        mem_ops();
        misc_ops();
        while (inst_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);      // catch late or extra results
        if (checked == NUM_INST && inst_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d instructions were checked", checked, NUM_INST);
            $display("SIMULATION FAILED");
            $fatal(1, "incomplete run");
        end
    end

    initial begin
        repeat (RST_CYCLES + 2 * NUM_INST + 50) @(posedge clk);
        $display("timeout, the instruction stream did not drain");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog");
    end

endmodule

//--- all.f
+incdir+verilog
+incdir+sim
verilog/riscv_pkg.sv
verilog/riscv_id_ex_if.sv
verilog/riscv_id_opt.sv
verilog/riscv_id_stage.sv
verilog/riscv_regfile.sv
verilog/riscv_exu.sv
verilog/riscv_exec_core.sv
sim/tb_riscv_exec_core.sv
